// File: include/qla_cfg.svh
`ifndef QLA_CFG_SVH
`define QLA_CFG_SVH

// ----------------------------------------------------------------------
// board geometry and bus widths
// ----------------------------------------------------------------------
`define QLA_NUM_AXES        4       // axes on the QLA
`define QLA_ADDR_W          16      // register address width
`define QLA_DATA_W          32      // register data width
`define QLA_CUR_W           16      // adc and dac current words
`define QLA_ID_W            4       // rotary switch width
`define QLA_DOUT_W          4       // digital outputs

// ----------------------------------------------------------------------
// address map
// ----------------------------------------------------------------------
// addr[15:12] space, addr[7:4] channel, addr[3:0] offset
`define QLA_ADDR_MAIN       4'h0    // main board space
`define QLA_CHAN_BOARD      4'h0    // channel 0 board registers
`define QLA_REG_STATUS      4'h0    // status and enables
`define QLA_REG_DIGIOUT     4'h6    // digital outputs
`define QLA_OFF_DAC_CTRL    4'h1    // dac command in axis channels 1..4

// ----------------------------------------------------------------------
// safety check
// ----------------------------------------------------------------------
`define QLA_CUR_MID         16'h8000    // zero current in offset binary
`define QLA_SAFETY_MARGIN   16'h0200    // slack on top of 2x command
`define QLA_SAFETY_COUNT    8           // over-limit cycles before trip
`define QLA_SAFETY_CNT_W    4           // counter width, holds COUNT-1

`endif

// File: design/qla_pkg.sv
`default_nettype none

`include "qla_cfg.svh"

package qla_pkg;

    // ------------------------------------------------------------------
    // register bus words
    // ------------------------------------------------------------------
    typedef logic [`QLA_ADDR_W-1:0] reg_addr_t;    // space|unused|chan|offset
    typedef logic [`QLA_DATA_W-1:0] reg_data_t;    // quadlet

    // ------------------------------------------------------------------
    // per-axis values
    // ------------------------------------------------------------------
    // offset binary, midscale is zero current
    typedef logic [`QLA_CUR_W-1:0] cur_t;

    // bit i is axis i+1
    typedef logic [`QLA_NUM_AXES-1:0] axis_mask_t;

    // rotary switch value after inversion
    typedef logic [`QLA_ID_W-1:0] board_id_t;

    // overcurrent detector
    typedef enum logic [1:0] {
        TRIP_IDLE,          // within limit
        TRIP_COUNTING,      // over limit, not yet long enough
        TRIP_LATCHED        // amp held off until cleared
    } trip_state_t;

endpackage

`default_nettype wire

// File: design/board_regs.sv
`default_nettype none

`include "qla_cfg.svh"

module board_regs (
    input  wire                             sysclk,
    input  wire                             reset,
    input  qla_pkg::reg_addr_t              reg_raddr,
    input  qla_pkg::reg_addr_t              reg_waddr,
    input  qla_pkg::reg_data_t              reg_wdata,
    input  wire                             reg_wen,
    input  qla_pkg::board_id_t              wenid,                  // active low switch
    input  qla_pkg::axis_mask_t             safety_amp_disable,
    output qla_pkg::reg_data_t              reg_rdata,              // combinational
    output qla_pkg::axis_mask_t             amp_enable_reg,
    output logic                            pwr_enable,
    output logic [`QLA_DOUT_W-1:0]          dout,
    output logic                            pwr_enable_cmd,         // one cycle
    output qla_pkg::axis_mask_t             amp_enable_cmd          // one cycle per axis
);

    // status register layout
    localparam int PWR_MASK_BIT = 19;       // write 1 to change power
    localparam int PWR_VAL_BIT  = 18;       // new power value
    localparam int AMP_MASK_LSB = 8;        // per-axis write mask, read as disables
    localparam int ID_LSB       = 24;       // board id field

    qla_pkg::board_id_t   board_id;
    qla_pkg::axis_mask_t  amp_mask;         // axes selected by this write
    qla_pkg::axis_mask_t  amp_val;
    logic                 wr_chan0;
    logic                 wen_status;
    logic                 wen_dout;

    assign board_id = ~wenid;

    // ------------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------------
    assign wr_chan0   = reg_wen && (reg_waddr[15:12] == `QLA_ADDR_MAIN)
                        && (reg_waddr[7:4] == `QLA_CHAN_BOARD);
    assign wen_status = wr_chan0 && (reg_waddr[3:0] == `QLA_REG_STATUS);
    assign wen_dout   = wr_chan0 && (reg_waddr[3:0] == `QLA_REG_DIGIOUT);

    assign amp_mask = reg_wdata[AMP_MASK_LSB +: `QLA_NUM_AXES];
    assign amp_val  = reg_wdata[0 +: `QLA_NUM_AXES];

    // power and axis enables with masked writes
    always_ff @(posedge sysclk) begin
        if (reset) begin
            pwr_enable     <= 1'b0;
            amp_enable_reg <= '0;
        end else if (wen_status) begin
            if (reg_wdata[PWR_MASK_BIT]) begin
                pwr_enable <= reg_wdata[PWR_VAL_BIT];
            end
            // unselected axes keep their enable
            amp_enable_reg <= (amp_enable_reg & ~amp_mask) | (amp_val & amp_mask);
        end
    end

    // clear pulses for the safety checks one cycle after the write
    always_ff @(posedge sysclk) begin
        if (reset) begin
            pwr_enable_cmd <= 1'b0;
            amp_enable_cmd <= '0;
        end else begin
            pwr_enable_cmd <= wen_status && reg_wdata[PWR_MASK_BIT] && reg_wdata[PWR_VAL_BIT];
            amp_enable_cmd <= wen_status ? (amp_mask & amp_val) : '0;
        end
    end

    // digital outputs
    always_ff @(posedge sysclk) begin
        if (reset) begin
            dout <= '0;
        end else if (wen_dout) begin
            dout <= reg_wdata[`QLA_DOUT_W-1:0];
        end
    end

    // ------------------------------------------------------------------
    // readback of an address already matched to channel 0
    // ------------------------------------------------------------------
    always_comb begin
        reg_rdata = '0;
        case (reg_raddr[3:0])
            `QLA_REG_STATUS: begin
                reg_rdata[ID_LSB +: `QLA_ID_W]            = board_id;
                reg_rdata[PWR_MASK_BIT]                   = pwr_enable;
                reg_rdata[AMP_MASK_LSB +: `QLA_NUM_AXES]  = safety_amp_disable;
                reg_rdata[0 +: `QLA_NUM_AXES]             = amp_enable_reg;
            end
            `QLA_REG_DIGIOUT: begin
                reg_rdata[`QLA_DOUT_W-1:0] = dout;
            end
            default: begin
                reg_rdata = '0;     // unmapped offset
            end
        endcase
    end

    // a clear pulse only reports an enable that is now set
    a_cmd_pulse: assert property (@(posedge sysclk) disable iff (reset)
        (!pwr_enable_cmd || pwr_enable) && ((amp_enable_cmd & ~amp_enable_reg) == '0));

endmodule

`default_nettype wire

// File: design/dac_cmd_regs.sv
`default_nettype none

`include "qla_cfg.svh"

module dac_cmd_regs (
    input  wire                                   sysclk,
    input  wire                                   reset,
    input  qla_pkg::reg_addr_t                    reg_raddr,
    input  qla_pkg::reg_addr_t                    reg_waddr,
    input  qla_pkg::reg_data_t                    reg_wdata,
    input  wire                                   reg_wen,
    output qla_pkg::reg_data_t                    reg_rdata,      // combinational
    output qla_pkg::cur_t [`QLA_NUM_AXES-1:0]     cur_cmd
);

    logic [3:0] wchan;      // write channel field
    logic [3:0] rchan;      // read channel field
    logic       wr_dac;     // dac offset write in main space
    logic       rd_dac;

    assign wchan = reg_waddr[7:4];
    assign rchan = reg_raddr[7:4];

    // ------------------------------------------------------------------
    // write decode, channel selects the axis
    // ------------------------------------------------------------------
    assign wr_dac = reg_wen && (reg_waddr[15:12] == `QLA_ADDR_MAIN)
                    && (reg_waddr[3:0] == `QLA_OFF_DAC_CTRL);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                cur_cmd[i] <= `QLA_CUR_MID;     // zero current
            end
        end else begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                // axis i lives in channel i+1
                if (wr_dac && (wchan == 4'(i + 1))) begin
                    cur_cmd[i] <= reg_wdata[`QLA_CUR_W-1:0];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // readback
    // ------------------------------------------------------------------
    assign rd_dac = (reg_raddr[3:0] == `QLA_OFF_DAC_CTRL);

    always_comb begin
        reg_rdata = '0;
        for (int i = 0; i < `QLA_NUM_AXES; i++) begin
            if (rd_dac && (rchan == 4'(i + 1))) begin
                reg_rdata = qla_pkg::reg_data_t'(cur_cmd[i]);     // zero extend
            end
        end
    end

    // board channel writes never touch the commands
    a_no_chan0: assert property (@(posedge sysclk) disable iff (reset)
        (reg_wen && (wchan == `QLA_CHAN_BOARD)) |=> $stable(cur_cmd));

endmodule

`default_nettype wire

// File: design/safety_check.sv
`default_nettype none

`include "qla_cfg.svh"

module safety_check (
    input  wire             sysclk,
    input  wire             reset,
    input  qla_pkg::cur_t   cur_in,         // measured, offset binary
    input  qla_pkg::cur_t   dac_in,         // commanded, offset binary
    input  wire             clear_disable,  // enable write pulse
    output logic            amp_disable
);

    localparam int CNT_W = `QLA_SAFETY_CNT_W;
    // count value on the last over-limit cycle before the trip
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`QLA_SAFETY_COUNT - 1);

    qla_pkg::cur_t          cur_mag;        // |feedback|
    qla_pkg::cur_t          dac_mag;        // |command|
    logic [`QLA_CUR_W+1:0]  limit;          // 2x command plus margin without overflow
    logic                   over_limit;

    qla_pkg::trip_state_t   state;
    logic [CNT_W-1:0]       count;          // consecutive over-limit cycles

    // ------------------------------------------------------------------
    // magnitudes around midscale
    // ------------------------------------------------------------------
    always_comb begin
        if (cur_in >= `QLA_CUR_MID) begin
            cur_mag = cur_in - `QLA_CUR_MID;
        end else begin
            cur_mag = `QLA_CUR_MID - cur_in;
        end
        if (dac_in >= `QLA_CUR_MID) begin
            dac_mag = dac_in - `QLA_CUR_MID;
        end else begin
            dac_mag = `QLA_CUR_MID - dac_in;
        end
    end

    assign limit      = {1'b0, dac_mag, 1'b0} + {2'b00, `QLA_SAFETY_MARGIN};
    assign over_limit = {2'b00, cur_mag} > limit;

    // ------------------------------------------------------------------
    // trip FSM
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset || clear_disable) begin
            state       <= qla_pkg::TRIP_IDLE;
            count       <= '0;
            amp_disable <= 1'b0;
        end else begin
            case (state)
                qla_pkg::TRIP_IDLE,
                qla_pkg::TRIP_COUNTING: begin
                    if (!over_limit) begin
                        state <= qla_pkg::TRIP_IDLE;     // streak broken
                        count <= '0;
                    end else if (count == CNT_LAST) begin
                        state       <= qla_pkg::TRIP_LATCHED;
                        amp_disable <= 1'b1;
                    end else begin
                        state <= qla_pkg::TRIP_COUNTING;
                        count <= count + 1'b1;
                    end
                end
                qla_pkg::TRIP_LATCHED: begin
                    amp_disable <= 1'b1;    // hold until cleared
                end
                default: begin
                    state       <= qla_pkg::TRIP_IDLE;
                    count       <= '0;
                    amp_disable <= 1'b0;
                end
            endcase
        end
    end

    // disable flop tracks the latched state
    a_latched: assert property (@(posedge sysclk) disable iff (reset)
        amp_disable == (state == qla_pkg::TRIP_LATCHED));

    // a trip ends a full streak of over-limit cycles
    a_trip_cause: assert property (@(posedge sysclk) disable iff (reset)
        $rose(amp_disable) |-> ($past(over_limit) && $past(over_limit, `QLA_SAFETY_COUNT)));

endmodule

`default_nettype wire

// File: design/qla_board_top.sv
`default_nettype none

`include "qla_cfg.svh"

module qla_board_top (
    input  wire                                   sysclk,
    input  wire                                   reset,
    input  qla_pkg::board_id_t                    wenid,      // rotary switch, active low

    // firewire host port
    input  qla_pkg::reg_addr_t                    fw_reg_raddr,
    input  qla_pkg::reg_addr_t                    fw_reg_waddr,
    input  qla_pkg::reg_data_t                    fw_reg_wdata,
    input  wire                                   fw_reg_wen,

    // ethernet host port
    input  qla_pkg::reg_addr_t                    eth_reg_raddr,
    input  wire                                   eth_read_en,
    input  qla_pkg::reg_addr_t                    eth_reg_waddr,
    input  qla_pkg::reg_data_t                    eth_reg_wdata,
    input  wire                                   eth_reg_wen,

    // measured motor current per axis
    input  qla_pkg::cur_t [`QLA_NUM_AXES-1:0]     cur_fb,

    output qla_pkg::reg_data_t                    reg_rdata,
    output qla_pkg::axis_mask_t                   amp_enable,
    output logic                                  pwr_enable,
    output logic [`QLA_DOUT_W-1:0]                dout,
    output qla_pkg::cur_t [`QLA_NUM_AXES-1:0]     cur_cmd
);

    // ------------------------------------------------------------------
    // merged internal bus
    // ------------------------------------------------------------------
    qla_pkg::reg_addr_t   reg_raddr;
    qla_pkg::reg_addr_t   reg_waddr;
    qla_pkg::reg_data_t   reg_wdata;
    logic                 reg_wen;

    qla_pkg::reg_data_t   board_rdata;    // channel 0
    qla_pkg::reg_data_t   dac_rdata;      // axis channels
    qla_pkg::reg_data_t   rdata_mux;

    qla_pkg::axis_mask_t  amp_enable_reg;         // stored axis enables
    qla_pkg::axis_mask_t  safety_amp_disable;     // latched trips
    qla_pkg::axis_mask_t  amp_enable_cmd;         // axis enable write pulses
    logic                 pwr_enable_cmd;         // power on write pulse

    // ethernet owns the read address only while reading
    assign reg_raddr = eth_read_en ? eth_reg_raddr : fw_reg_raddr;
    // ethernet wins a same-cycle write
    assign reg_waddr = eth_reg_wen ? eth_reg_waddr : fw_reg_waddr;
    assign reg_wdata = eth_reg_wen ? eth_reg_wdata : fw_reg_wdata;
    assign reg_wen   = fw_reg_wen | eth_reg_wen;

    // read mux, other spaces are not built and read zero
    always_comb begin
        if (reg_raddr[15:12] != `QLA_ADDR_MAIN) begin
            rdata_mux = '0;
        end else if (reg_raddr[7:4] == `QLA_CHAN_BOARD) begin
            rdata_mux = board_rdata;
        end else begin
            rdata_mux = dac_rdata;      // zero for unmapped axis offsets
        end
    end

    // one cycle read latency
    always_ff @(posedge sysclk) begin
        if (reset) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rdata_mux;
        end
    end

    // power gates everything, a trip drops its own axis
    assign amp_enable = amp_enable_reg & {`QLA_NUM_AXES{pwr_enable}} & ~safety_amp_disable;

    // ------------------------------------------------------------------
    // register blocks
    // ------------------------------------------------------------------
    board_regs chan0 (
        .sysclk             (sysclk),
        .reset              (reset),
        .reg_raddr          (reg_raddr),
        .reg_waddr          (reg_waddr),
        .reg_wdata          (reg_wdata),
        .reg_wen            (reg_wen),
        .wenid              (wenid),
        .safety_amp_disable (safety_amp_disable),
        .reg_rdata          (board_rdata),
        .amp_enable_reg     (amp_enable_reg),
        .pwr_enable         (pwr_enable),
        .dout               (dout),
        .pwr_enable_cmd     (pwr_enable_cmd),
        .amp_enable_cmd     (amp_enable_cmd)
    );

    dac_cmd_regs dac (
        .sysclk     (sysclk),
        .reset      (reset),
        .reg_raddr  (reg_raddr),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .reg_wen    (reg_wen),
        .reg_rdata  (dac_rdata),
        .cur_cmd    (cur_cmd)
    );

    // ------------------------------------------------------------------
    // overcurrent check per axis
    // ------------------------------------------------------------------
    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_safe
        safety_check safe (
            .sysclk         (sysclk),
            .reset          (reset),
            .cur_in         (cur_fb[i]),
            .dac_in         (cur_cmd[i]),
            .clear_disable  (pwr_enable_cmd | amp_enable_cmd[i]),   // re-enable clears
            .amp_disable    (safety_amp_disable[i])
        );
    end

endmodule

`default_nettype wire

// File: tb/tb_qla_board.sv
`default_nettype none

`include "qla_cfg.svh"

module tb_qla_board;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 5;
    localparam int WD_MARGIN    = 20;     // spare cycles for the watchdog
    localparam int FBW          = `QLA_NUM_AXES * `QLA_CUR_W;

    localparam logic       FW      = 1'b0;
    localparam logic       ETH     = 1'b1;
    localparam logic [1:0] OP_HOLD = 2'd0;
    localparam logic [1:0] OP_WR   = 2'd1;
    localparam logic [1:0] OP_RD   = 2'd2;
    localparam logic [1:0] OP_WR2  = 2'd3;     // both hosts write at once

    localparam qla_pkg::board_id_t WENID   = 4'b1010;          // switch reads as id 5
    localparam qla_pkg::reg_data_t ID_BITS = 32'h0500_0000;
    localparam qla_pkg::reg_data_t PWR_BIT = 32'h0008_0000;    // status bit 19
    localparam logic [FBW-1:0]     FB_MID  = {`QLA_NUM_AXES{`QLA_CUR_MID}};

    localparam qla_pkg::reg_addr_t STATUS_ADDR =
        {`QLA_ADDR_MAIN, 4'h0, `QLA_CHAN_BOARD, `QLA_REG_STATUS};
    localparam qla_pkg::reg_addr_t DOUT_ADDR =
        {`QLA_ADDR_MAIN, 4'h0, `QLA_CHAN_BOARD, `QLA_REG_DIGIOUT};

    typedef struct packed {
        logic                   eth;        // host port
        logic [1:0]             op;
        qla_pkg::reg_addr_t     addr;
        qla_pkg::reg_data_t     wdata;
        logic [FBW-1:0]         fb;         // feedback, axis 0 in low bits
        qla_pkg::reg_data_t     exp_rd;     // read rows only
        qla_pkg::axis_mask_t    exp_amp;    // after this row's edge
    } row_t;

    // ----------------------------------------------------------------------
    // DUT and stimulus signals
    // ----------------------------------------------------------------------
    logic                                   sysclk;
    logic                                   reset;
    qla_pkg::board_id_t                     wenid;
    qla_pkg::reg_addr_t                     fw_reg_raddr;
    qla_pkg::reg_addr_t                     fw_reg_waddr;
    qla_pkg::reg_data_t                     fw_reg_wdata;
    logic                                   fw_reg_wen;
    qla_pkg::reg_addr_t                     eth_reg_raddr;
    logic                                   eth_read_en;
    qla_pkg::reg_addr_t                     eth_reg_waddr;
    qla_pkg::reg_data_t                     eth_reg_wdata;
    logic                                   eth_reg_wen;
    qla_pkg::cur_t [`QLA_NUM_AXES-1:0]      cur_fb;
    qla_pkg::reg_data_t                     reg_rdata;
    qla_pkg::axis_mask_t                    amp_enable;
    logic                                   pwr_enable;
    logic [`QLA_DOUT_W-1:0]                 dout;
    qla_pkg::cur_t [`QLA_NUM_AXES-1:0]      cur_cmd;

    row_t           rows[$];
    int             num_rows = 0;
    logic [31:0]    lfsr_state = 32'he60c_968e;

    qla_board_top dut0 (
        .sysclk         (sysclk),
        .reset          (reset),
        .wenid          (wenid),
        .fw_reg_raddr   (fw_reg_raddr),
        .fw_reg_waddr   (fw_reg_waddr),
        .fw_reg_wdata   (fw_reg_wdata),
        .fw_reg_wen     (fw_reg_wen),
        .eth_reg_raddr  (eth_reg_raddr),
        .eth_read_en    (eth_read_en),
        .eth_reg_waddr  (eth_reg_waddr),
        .eth_reg_wdata  (eth_reg_wdata),
        .eth_reg_wen    (eth_reg_wen),
        .cur_fb         (cur_fb),
        .reg_rdata      (reg_rdata),
        .amp_enable     (amp_enable),
        .pwr_enable     (pwr_enable),
        .dout           (dout),
        .cur_cmd        (cur_cmd)
    );

    always #(PERIOD / 2) sysclk = ~sysclk;

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    // taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);     // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic qla_pkg::reg_addr_t dac_addr(input int ax);
        return {`QLA_ADDR_MAIN, 4'h0, 4'(ax + 1), `QLA_OFF_DAC_CTRL};   // channel ax+1
    endfunction

    // only the low 16 bits are stored
    function automatic qla_pkg::reg_data_t dac_readback(input qla_pkg::reg_data_t w);
        return {16'h0000, w[15:0]};
    endfunction

    // midscale everywhere except one axis
    function automatic logic [FBW-1:0] fb_one(input int idx, input qla_pkg::cur_t val);
        logic [FBW-1:0] v;
        v = FB_MID;
        v[idx*`QLA_CUR_W +: `QLA_CUR_W] = val;
        return v;
    endfunction

    task automatic add_row(input logic eth, input logic [1:0] op,
                           input qla_pkg::reg_addr_t addr, input qla_pkg::reg_data_t wdata,
                           input logic [FBW-1:0] fb, input qla_pkg::reg_data_t exp_rd,
                           input qla_pkg::axis_mask_t exp_amp);
        row_t r;
        r.eth     = eth;
        r.op      = op;
        r.addr    = addr;
        r.wdata   = wdata;
        r.fb      = fb;
        r.exp_rd  = exp_rd;
        r.exp_amp = exp_amp;
        rows.push_back(r);
    endtask

    task automatic value_error(input string name, input logic [63:0] exp_v,
                               input logic [63:0] got_v);
        $display("ERR t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp_v, got_v);
        $display("Test failed");
        $fatal(1, "value mismatch");
    endtask

    // ----------------------------------------------------------------------
    // stimulus table
    // ----------------------------------------------------------------------
    task automatic build_table();
        qla_pkg::reg_data_t w [0:5];    // random dac words
        for (int k = 0; k < 6; k++) begin
            w[k] = rand_bits(32);
        end
        // dac commands from both hosts, read back from the other side
        add_row(FW,  OP_WR, dac_addr(0), w[0], FB_MID, '0, 4'h0);
        add_row(FW,  OP_WR, dac_addr(1), w[1], FB_MID, '0, 4'h0);
        add_row(ETH, OP_WR, dac_addr(2), w[2], FB_MID, '0, 4'h0);
        add_row(ETH, OP_WR, dac_addr(3), w[3], FB_MID, '0, 4'h0);
        for (int ax = 0; ax < 4; ax++) begin
            add_row((ax < 2) ? ETH : FW, OP_RD, dac_addr(ax), '0, FB_MID,
                    dac_readback(w[ax]), 4'h0);
        end
        add_row(FW,  OP_RD, 16'h0005, '0, FB_MID, '0, 4'h0);    // unused board offset
        add_row(ETH, OP_RD, 16'h0012, '0, FB_MID, '0, 4'h0);    // unused axis offset
        add_row(FW,  OP_RD, 16'h1011, '0, FB_MID, '0, 4'h0);    // other space
        add_row(ETH, OP_WR, dac_addr(0), w[4], FB_MID, '0, 4'h0);
        add_row(FW,  OP_RD, dac_addr(0), '0, FB_MID, dac_readback(w[4]), 4'h0);
        // same-cycle write, fw gets the inverted word
        add_row(ETH, OP_WR2, dac_addr(1), w[5], FB_MID, '0, 4'h0);
        add_row(FW,  OP_RD, dac_addr(1), '0, FB_MID, dac_readback(w[5]), 4'h0);

        // status register, masked writes
        add_row(FW,  OP_RD, STATUS_ADDR, '0, FB_MID, ID_BITS, 4'h0);
        add_row(FW,  OP_WR, STATUS_ADDR, 32'h0000_0305, FB_MID, '0, 4'h0);    // axis 1 only
        add_row(ETH, OP_RD, STATUS_ADDR, '0, FB_MID, ID_BITS | 32'h1, 4'h0);
        add_row(ETH, OP_WR, STATUS_ADDR, 32'h000C_0000, FB_MID, '0, 4'h1);    // power on
        add_row(FW,  OP_WR, STATUS_ADDR, 32'h0000_0F0E, FB_MID, '0, 4'hE);
        add_row(FW,  OP_RD, STATUS_ADDR, '0, FB_MID, ID_BITS | PWR_BIT | 32'hE, 4'hE);
        add_row(ETH, OP_WR, STATUS_ADDR, 32'h0008_0000, FB_MID, '0, 4'h0);    // power off
        add_row(FW,  OP_RD, STATUS_ADDR, '0, FB_MID, ID_BITS | 32'hE, 4'h0);
        add_row(ETH, OP_WR, STATUS_ADDR, 32'h000C_0F0F, FB_MID, '0, 4'hF);

        // axis 2 command +0x100, limit 0x400 from midscale
        add_row(ETH, OP_WR, dac_addr(1), 32'h0000_8100, FB_MID, '0, 4'hF);
        for (int k = 0; k < 10; k++) begin
            add_row(FW, OP_HOLD, '0, '0, fb_one(1, k[0] ? 16'h8400 : 16'h7C00), '0, 4'hF);
        end
        for (int k = 0; k < 7; k++) begin
            add_row(FW, OP_HOLD, '0, '0, fb_one(1, 16'h8401), '0, 4'hF);
        end
        add_row(FW, OP_HOLD, '0, '0, fb_one(1, 16'h8400), '0, 4'hF);     // streak broken
        for (int k = 0; k < `QLA_SAFETY_COUNT; k++) begin
            add_row(FW, OP_HOLD, '0, '0, fb_one(1, 16'h7BFF), '0,
                    (k == `QLA_SAFETY_COUNT - 1) ? 4'hD : 4'hF);
        end
        add_row(FW, OP_HOLD, '0, '0, FB_MID, '0, 4'hD);
        add_row(FW, OP_RD, STATUS_ADDR, '0, FB_MID, ID_BITS | PWR_BIT | 32'h20F, 4'hD);
        add_row(FW, OP_WR, STATUS_ADDR, 32'h0000_0202, FB_MID, '0, 4'hD);    // re-enable axis 2
        add_row(FW, OP_HOLD, '0, '0, FB_MID, '0, 4'hF);
        add_row(FW, OP_RD, STATUS_ADDR, '0, FB_MID, ID_BITS | PWR_BIT | 32'hF, 4'hF);
        for (int k = 0; k < `QLA_SAFETY_COUNT; k++) begin
            add_row(FW, OP_HOLD, '0, '0, fb_one(1, 16'h8401), '0,
                    (k == `QLA_SAFETY_COUNT - 1) ? 4'hD : 4'hF);
        end
        add_row(FW,  OP_HOLD, '0, '0, FB_MID, '0, 4'hD);
        add_row(ETH, OP_WR, STATUS_ADDR, 32'h000C_0000, FB_MID, '0, 4'hD);   // power write clears
        add_row(FW,  OP_HOLD, '0, '0, FB_MID, '0, 4'hF);
        add_row(ETH, OP_RD, STATUS_ADDR, '0, FB_MID, ID_BITS | PWR_BIT | 32'hF, 4'hF);

        // digital outputs
        add_row(FW,  OP_WR, DOUT_ADDR, 32'hFFFF_FFA5, FB_MID, '0, 4'hF);
        add_row(ETH, OP_RD, DOUT_ADDR, '0, FB_MID, 32'h0000_0005, 4'hF);
        add_row(ETH, OP_WR, DOUT_ADDR, 32'h0000_000A, FB_MID, '0, 4'hF);
        add_row(FW,  OP_RD, DOUT_ADDR, '0, FB_MID, 32'h0000_000A, 4'hF);
        add_row(FW,  OP_HOLD, '0, '0, FB_MID, '0, 4'hF);     // flush, not checked
    endtask

    // ----------------------------------------------------------------------
    // drive and check
    // ----------------------------------------------------------------------
    task automatic apply_row(input row_t r);
        fw_reg_wen  <= 1'b0;
        eth_reg_wen <= 1'b0;
        eth_read_en <= 1'b0;
        cur_fb      <= r.fb;
        case (r.op)
            OP_WR: begin
                if (r.eth) begin
                    eth_reg_waddr <= r.addr;
                    eth_reg_wdata <= r.wdata;
                    eth_reg_wen   <= 1'b1;
                end else begin
                    fw_reg_waddr <= r.addr;
                    fw_reg_wdata <= r.wdata;
                    fw_reg_wen   <= 1'b1;
                end
            end
            OP_RD: begin
                if (r.eth) begin
                    eth_reg_raddr <= r.addr;
                    eth_read_en   <= 1'b1;
                end else begin
                    fw_reg_raddr <= r.addr;
                end
            end
            OP_WR2: begin
                fw_reg_waddr  <= r.addr;
                fw_reg_wdata  <= ~r.wdata;     // loser of the same-cycle write
                fw_reg_wen    <= 1'b1;
                eth_reg_waddr <= r.addr;
                eth_reg_wdata <= r.wdata;
                eth_reg_wen   <= 1'b1;
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_row(input row_t r);
        int ax;
        ax = int'(r.addr[7:4]) - 1;
        assert (amp_enable == r.exp_amp)
            else value_error("amp_enable", 64'(r.exp_amp), 64'(amp_enable));
        if (r.op == OP_RD) begin
            assert (reg_rdata == r.exp_rd)
                else value_error("reg_rdata", 64'(r.exp_rd), 64'(reg_rdata));
            if (r.addr[3:0] == `QLA_OFF_DAC_CTRL && ax >= 0 && ax < `QLA_NUM_AXES
                    && r.addr[15:12] == `QLA_ADDR_MAIN) begin
                assert (cur_cmd[ax] == r.exp_rd[15:0])
                    else value_error("cur_cmd", 64'(r.exp_rd[15:0]), 64'(cur_cmd[ax]));
            end
            if (r.addr == DOUT_ADDR) begin
                assert (dout == r.exp_rd[3:0])
                    else value_error("dout", 64'(r.exp_rd[3:0]), 64'(dout));
            end
            if (r.addr == STATUS_ADDR) begin
                assert (pwr_enable == r.exp_rd[19])
                    else value_error("pwr_enable", 64'(r.exp_rd[19]), 64'(pwr_enable));
            end
        end
    endtask

    task automatic check_reset();
        assert (amp_enable == '0) else value_error("amp_enable", 64'h0, 64'(amp_enable));
        assert (pwr_enable == 1'b0) else value_error("pwr_enable", 64'h0, 64'(pwr_enable));
        assert (dout == '0) else value_error("dout", 64'h0, 64'(dout));
        assert (reg_rdata == '0) else value_error("reg_rdata", 64'h0, 64'(reg_rdata));
        assert (cur_cmd == FB_MID) else value_error("cur_cmd", FB_MID, 64'(cur_cmd));
    endtask

    // ----------------------------------------------------------------------
    // main sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin
        sysclk        = 1'b0;
        reset         <= 1'b1;
        wenid         <= WENID;
        fw_reg_raddr  <= '0;
        fw_reg_waddr  <= '0;
        fw_reg_wdata  <= '0;
        fw_reg_wen    <= 1'b0;
        eth_reg_raddr <= '0;
        eth_read_en   <= 1'b0;
        eth_reg_waddr <= '0;
        eth_reg_wdata <= '0;
        eth_reg_wen   <= 1'b0;
        cur_fb        <= FB_MID;
        build_table();
        num_rows = rows.size();
        repeat (RESET_CYCLES) @(posedge sysclk);
        reset <= 1'b0;
        @(negedge sysclk);
        check_reset();
        for (int i = 0; i < num_rows; i++) begin
            @(posedge sysclk);
            apply_row(rows[i]);
            @(negedge sysclk);          // outputs settled after the previous row's edge
            if (i > 0) begin
                check_row(rows[i - 1]);
            end
        end
        $display("Test passed");
        $finish;
    end

    initial begin
        wait (num_rows > 0);
        #((num_rows + RESET_CYCLES + WD_MARGIN) * PERIOD);
        $display("timeout: run did not finish within %0d clock cycles",
                 num_rows + RESET_CYCLES + WD_MARGIN);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
design/qla_pkg.sv
design/board_regs.sv
design/dac_cmd_regs.sv
design/safety_check.sv
design/qla_board_top.sv
tb/tb_qla_board.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the register bus testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_qla_board -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "FAIL: verilator build error, see build.log"
    exit 1
fi

./obj_dir/Vtb_qla_board > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "FAIL: simulation exited with status $status, see sim.log"
    exit 1
fi

grep -qx "Test passed" sim.log
if [ $? -ne 0 ]; then
    echo "FAIL: pass line not found in sim.log"
    exit 1
fi

echo "PASS"
exit 0
